/* project.f */
rtl/core_pkg.sv
rtl/ex_block.sv
rtl/register_file.sv
rtl/load_store_unit.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/core_top.sv
tests/tb_clock_gen.sv
tests/tb_core.sv

/* tests/tb_core.sv */
// Testbench of the core
//   instruction and data memory models with grant and response delays
//   instruction encoders and directed program tests
//   store checks and watchdog

`timescale 1ns/1ps

module tb_core;

  import core_pkg::*;

  localparam word_t       boot_pc     = 32'h0000_0100;
  localparam word_t       nop         = 32'h0000_0013;
  localparam int unsigned num_tests   = 7;
  localparam int unsigned test_cycles = 2000;

  logic  clk;
  logic  rst_n;
  logic  reset_req    = 1'b0;
  logic  fetch_enable = 1'b0;
  word_t boot_addr    = boot_pc;

  logic  instr_req;
  logic  instr_gnt    = 1'b0;
  logic  instr_rvalid = 1'b0;
  word_t instr_addr;
  word_t instr_rdata  = '0;
  logic  data_req;
  logic  data_gnt     = 1'b0;
  logic  data_rvalid  = 1'b0;
  logic  data_we;
  word_t data_addr;
  word_t data_wdata;
  word_t data_rdata   = '0;

  word_t       imem [256];
  word_t       dmem [256];
  int unsigned prog_idx;
  bit          random_mode = 1'b0;
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       fetch_log [$];

  // Memory model state
  int unsigned i_gnt_wait = 0;
  logic        i_rsp_pend = 1'b0;
  int unsigned i_rsp_wait = 0;
  word_t       i_rsp_addr = '0;
  int unsigned d_gnt_wait = 0;
  logic        d_rsp_pend = 1'b0;
  int unsigned d_rsp_wait = 0;
  word_t       d_rsp_addr = '0;

  tb_clock_gen #(
    .period_ns    ( 4 ),
    .reset_cycles ( 3 )
  ) clock_gen (
    .reset_req_i ( reset_req ),
    .clk_o       ( clk       ),
    .rst_no      ( rst_n     )
  );

  core_top #(
    .rv32e ( 1'b0 )
  ) dut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .fetch_enable_i ( fetch_enable ),
    .boot_addr_i    ( boot_addr    ),
    .instr_req_o    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  ),
    .data_we_o      ( data_we      ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_rdata_i   ( data_rdata   )
  );

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////

  function automatic word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc_op_imm};
  endfunction

  function automatic word_t rr_op(logic [6:0] funct7, logic [2:0] funct3,
                                  reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return {funct7, rs2, rs1, funct3, rd, opc_op};
  endfunction

  // Loads and stores use x0 as base
  function automatic word_t lw(reg_addr_t rd, logic [11:0] imm);
    return {imm, 5'd0, 3'b010, rd, opc_load};
  endfunction

  function automatic word_t sw(reg_addr_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic word_t lui(reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, opc_lui};
  endfunction

  function automatic word_t jal(reg_addr_t rd, logic [20:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, opc_jal};
  endfunction

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int unsigned pick_delay();
    if (random_mode) begin
      return $urandom % 4;
    end
    return 0;
  endfunction

  task automatic fail_with(string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic emit(word_t instr);
    imem[prog_idx] = instr;
    prog_idx++;
  endtask

  task automatic expect_store(word_t addr, word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic check_store(word_t addr, word_t wdata);
    word_t want_addr;
    word_t want_data;
    assert (exp_addr.size() != 0)
      else fail_with($sformatf("Store to address %h came after the last expected one", addr));
    want_addr = exp_addr.pop_front();
    want_data = exp_data.pop_front();
    assert (addr == want_addr)
      else fail_with($sformatf("[FAIL] data_addr_o = %h, expected %h", addr, want_addr));
    assert (wdata == want_data)
      else fail_with($sformatf("[FAIL] data_wdata_o = %h, expected %h", wdata, want_data));
  endtask

  task automatic check_idle_ports();
    assert (!instr_req)
      else fail_with($sformatf("[FAIL] instr_req_o = %h, expected 0", instr_req));
    assert (!data_req)
      else fail_with($sformatf("[FAIL] data_req_o = %h, expected 0", data_req));
  endtask

  // Returns on a falling edge with fetch still disabled
  task automatic reset_core();
    @(negedge clk);
    fetch_enable = 1'b0;
    reset_req    = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    foreach (imem[i]) imem[i] = nop;
    foreach (dmem[i]) dmem[i] = '0;
    prog_idx = boot_pc[9:2];
    exp_addr.delete();
    exp_data.delete();
    fetch_log.delete();
    while (!rst_n) begin
      @(posedge clk);
      check_idle_ports();
      @(negedge clk);
    end
  endtask

  task automatic wait_for_stores();
    while (exp_addr.size() != 0) @(negedge clk);
  endtask

  task automatic run_program();
    fetch_enable = 1'b1;
    wait_for_stores();
  endtask

  ////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      i_rsp_pend <= 1'b0;
      i_gnt_wait <= pick_delay();
    end else begin
      if (instr_rvalid) begin
        i_rsp_pend <= 1'b0;
      end else if (i_rsp_pend && i_rsp_wait != 0) begin
        i_rsp_wait <= i_rsp_wait - 1;
      end
      if (instr_req && instr_gnt) begin
        i_rsp_pend <= 1'b1;
        i_rsp_addr <= instr_addr;
        i_rsp_wait <= pick_delay();
        i_gnt_wait <= pick_delay();
        fetch_log.push_back(instr_addr);
      end else if (instr_req && i_gnt_wait != 0) begin
        i_gnt_wait <= i_gnt_wait - 1;
      end
    end
  end

  // Grant offered whenever nothing is outstanding
  always @(negedge clk) begin
    instr_gnt    = rst_n && !i_rsp_pend && (i_gnt_wait == 0);
    instr_rvalid = i_rsp_pend && (i_rsp_wait == 0);
    instr_rdata  = instr_rvalid ? imem[i_rsp_addr[9:2]] : '0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      d_rsp_pend <= 1'b0;
      d_gnt_wait <= pick_delay();
    end else begin
      if (data_rvalid) begin
        d_rsp_pend <= 1'b0;
      end else if (d_rsp_pend && d_rsp_wait != 0) begin
        d_rsp_wait <= d_rsp_wait - 1;
      end
      if (data_req && data_gnt) begin
        d_rsp_pend <= 1'b1;
        d_rsp_addr <= data_addr;
        d_rsp_wait <= pick_delay();
        d_gnt_wait <= pick_delay();
        if (data_we) begin
          check_store(data_addr, data_wdata);
        end
      end else if (data_req && d_gnt_wait != 0) begin
        d_gnt_wait <= d_gnt_wait - 1;
      end
    end
  end

  always @(negedge clk) begin
    data_gnt    = rst_n && !d_rsp_pend && (d_gnt_wait == 0);
    data_rvalid = d_rsp_pend && (d_rsp_wait == 0);
    data_rdata  = data_rvalid ? dmem[d_rsp_addr[9:2]] : '0;
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic verify_boot();
    reset_core();
    emit(addi(5'd1, 5'd0, 12'd5));
    emit(addi(5'd2, 5'd1, 12'd3));
    emit(sw(5'd2, 12'h200));
    expect_store(32'h200, sext12(12'd5) + sext12(12'd3));
    // Out of reset but not yet enabled
    repeat (3) begin
      @(posedge clk);
      check_idle_ports();
      @(negedge clk);
    end
    fetch_enable = 1'b1;
    @(posedge clk);
    assert (instr_req)
      else fail_with($sformatf("[FAIL] instr_req_o = %h, expected 1", instr_req));
    assert (instr_addr == boot_pc)
      else fail_with($sformatf("[FAIL] instr_addr_o = %h, expected %h", instr_addr, boot_pc));
    @(negedge clk);
    wait_for_stores();
    assert (fetch_log.size() > 1 && fetch_log[0] == boot_pc)
      else fail_with("First instruction fetch missing or not at the boot address");
    for (int i = 1; i < fetch_log.size(); i++) begin
      assert (fetch_log[i] == fetch_log[i - 1] + 32'd4)
        else fail_with($sformatf("[FAIL] instr_addr_o = %h, expected %h",
                                 fetch_log[i], fetch_log[i - 1] + 32'd4));
    end
  endtask

  task automatic alu_ops();
    word_t a;
    word_t b;
    reset_core();
    a = sext12(12'hff9);
    b = sext12(12'h064);
    emit(addi(5'd1, 5'd0, 12'hff9));
    emit(addi(5'd2, 5'd0, 12'h064));
    emit(rr_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(sw(5'd3, 12'h200));
    emit(rr_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    emit(sw(5'd4, 12'h204));
    emit(rr_op(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    emit(sw(5'd5, 12'h208));
    emit(rr_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    emit(sw(5'd6, 12'h20c));
    emit(rr_op(7'h00, 3'b100, 5'd17, 5'd1, 5'd2));
    emit(sw(5'd17, 12'h210));
    emit(rr_op(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
    emit(sw(5'd8, 12'h214));
    emit(rr_op(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
    emit(sw(5'd9, 12'h218));
    expect_store(32'h200, a + b);
    expect_store(32'h204, a - b);
    expect_store(32'h208, a & b);
    expect_store(32'h20c, a | b);
    expect_store(32'h210, a ^ b);
    // Signed compare of -7 with 100
    expect_store(32'h214, 32'd1);
    expect_store(32'h218, 32'd0);
    run_program();
  endtask

  task automatic lui_and_zero_reg();
    reset_core();
    emit(lui(5'd10, 20'habcde));
    emit(sw(5'd10, 12'h220));
    // Write to x0 must not stick
    emit(addi(5'd0, 5'd0, 12'h123));
    emit(sw(5'd0, 12'h224));
    expect_store(32'h220, {20'habcde, 12'h000});
    expect_store(32'h224, 32'h0);
    run_program();
  endtask

  task automatic load_store_path();
    reset_core();
    dmem[32'h300 >> 2] = 32'h1234_5678;
    emit(lw(5'd11, 12'h300));
    emit(addi(5'd12, 5'd11, 12'h001));
    emit(sw(5'd11, 12'h304));
    emit(sw(5'd12, 12'h308));
    expect_store(32'h304, 32'h1234_5678);
    expect_store(32'h308, 32'h1234_5678 + sext12(12'h001));
    run_program();
  endtask

  task automatic jump_and_link();
    word_t jal_pc;
    reset_core();
    jal_pc = boot_pc + 32'd4;
    emit(addi(5'd1, 5'd0, 12'h055));
    emit(jal(5'd5, 21'd8));
    // Skipped by the jump
    emit(sw(5'd1, 12'h230));
    emit(sw(5'd5, 12'h234));
    expect_store(32'h234, jal_pc + 32'd4);
    run_program();
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h568c_79e5));
    verify_boot();
    alu_ops();
    lui_and_zero_reg();
    load_store_path();
    jump_and_link();
    // Same programs under random grant and response delays
    random_mode = 1'b1;
    alu_ops();
    load_store_path();
    $display("test passed");
    $finish;
  end

  initial begin
    repeat (num_tests * test_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles before the last expected store",
             num_tests * test_cycles);
    $display("test failed");
    $fatal(1, "simulation stopped");
  end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and reset
//   free-running clock
//   active-low reset, held for a few cycles at start and on request

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned period_ns    = 4,
  parameter int unsigned reset_cycles = 3
) (
  input  logic reset_req_i,
  output logic clk_o,
  output logic rst_no
);

  logic        rst_q     = 1'b0;
  int unsigned rst_cnt_q = 0;

  assign rst_no = rst_q;

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Reset released after reset_cycles rising edges
  always @(posedge clk_o) begin
    if (reset_req_i) begin
      rst_q     <= 1'b0;
      rst_cnt_q <= 0;
    end else if (rst_cnt_q < reset_cycles) begin
      rst_cnt_q <= rst_cnt_q + 1;
      if (rst_cnt_q == reset_cycles - 1) begin
        rst_q <= 1'b1;
      end
    end
  end

endmodule

/* rtl/core_top.sv */
// Top level of the core
//   IF stage, ID stage, register file, execute block and LSU
//   instruction and data ports with req/gnt/rvalid handshake

`timescale 1ns/1ps

module core_top #(
  parameter bit rv32e = 1'b0
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,

  // Instruction port
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,

  // Data port
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);

  import core_pkg::*;

  // IF to ID
  logic      instr_valid_id;
  word_t     instr_id;
  word_t     pc_id;
  logic      id_ready;

  // Jump redirect
  logic      pc_set;
  word_t     jump_offset;
  word_t     jump_target;

  // Register file
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rd_we;
  reg_addr_t rd_addr;
  word_t     rd_wdata;

  // ALU
  alu_op_e   alu_op;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;

  // ID to LSU
  logic      lsu_req;
  logic      lsu_we;
  word_t     lsu_wdata;
  logic      lsu_done;
  word_t     lsu_rdata;

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////

  if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_valid_o  ( instr_valid_id ),
    .instr_o        ( instr_id       ),
    .pc_o           ( pc_id          ),
    .id_ready_i     ( id_ready       ),
    .pc_set_i       ( pc_set         ),
    .jump_target_i  ( jump_target    )
  );

  ////////////////////////////////////////
  // Decode and write-back
  ////////////////////////////////////////

  id_stage id_stage_i (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .instr_valid_i ( instr_valid_id ),
    .instr_i       ( instr_id       ),
    .pc_i          ( pc_id          ),
    .id_ready_o    ( id_ready       ),
    .pc_set_o      ( pc_set         ),
    .jump_offset_o ( jump_offset    ),
    .rs1_addr_o    ( rs1_addr       ),
    .rs2_addr_o    ( rs2_addr       ),
    .rs1_data_i    ( rs1_data       ),
    .rs2_data_i    ( rs2_data       ),
    .rd_we_o       ( rd_we          ),
    .rd_addr_o     ( rd_addr        ),
    .rd_wdata_o    ( rd_wdata       ),
    .alu_op_o      ( alu_op         ),
    .alu_a_o       ( alu_a          ),
    .alu_b_o       ( alu_b          ),
    .alu_result_i  ( alu_result     ),
    .lsu_req_o     ( lsu_req        ),
    .lsu_we_o      ( lsu_we         ),
    .lsu_wdata_o   ( lsu_wdata      ),
    .lsu_done_i    ( lsu_done       ),
    .lsu_rdata_i   ( lsu_rdata      )
  );

  register_file #(
    .rv32e ( rv32e )
  ) register_file_i (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .rs1_addr_i ( rs1_addr ),
    .rs2_addr_i ( rs2_addr ),
    .rs1_data_o ( rs1_data ),
    .rs2_data_o ( rs2_data ),
    .we_i       ( rd_we    ),
    .waddr_i    ( rd_addr  ),
    .wdata_i    ( rd_wdata )
  );

  ////////////////////////////////////////
  // Execute and memory access
  ////////////////////////////////////////

  ex_block ex_block_i (
    .alu_op_i      ( alu_op      ),
    .alu_a_i       ( alu_a       ),
    .alu_b_i       ( alu_b       ),
    .alu_result_o  ( alu_result  ),
    .pc_i          ( pc_id       ),
    .jump_offset_i ( jump_offset ),
    .jump_target_o ( jump_target )
  );

  // Memory address comes straight from the ALU result
  load_store_unit load_store_unit_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .lsu_req_i     ( lsu_req       ),
    .lsu_we_i      ( lsu_we        ),
    .lsu_addr_i    ( alu_result    ),
    .lsu_wdata_i   ( lsu_wdata     ),
    .lsu_done_o    ( lsu_done      ),
    .lsu_rdata_o   ( lsu_rdata     ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rdata_i  ( data_rdata_i  )
  );

endmodule

/* rtl/id_stage.sv */
// Instruction decode stage
//   decoder, immediates and ALU operand selection
//   register write-back from ALU, immediate or load data
//   controller FSM that stalls during memory accesses

`timescale 1ns/1ps

module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,

  // From IF stage
  input  logic                instr_valid_i,
  input  core_pkg::word_t     instr_i,
  input  core_pkg::word_t     pc_i,
  output logic                id_ready_o,
  output logic                pc_set_o,
  output core_pkg::word_t     jump_offset_o,

  // Register file
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  output logic                rd_we_o,
  output core_pkg::reg_addr_t rd_addr_o,
  output core_pkg::word_t     rd_wdata_o,

  // ALU
  output core_pkg::alu_op_e   alu_op_o,
  output core_pkg::word_t     alu_a_o,
  output core_pkg::word_t     alu_b_o,
  input  core_pkg::word_t     alu_result_i,

  // Load/store unit
  output logic                lsu_req_o,
  output logic                lsu_we_o,
  output core_pkg::word_t     lsu_wdata_o,
  input  logic                lsu_done_i,
  input  core_pkg::word_t     lsu_rdata_i
);

  import core_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_u;
  word_t       imm_j;

  logic        wb_alu;
  logic        wb_imm;
  logic        is_jal;
  logic        is_mem;
  logic        fire;

  // Pending load destination
  logic        load_q;
  reg_addr_t   load_rd_q;

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  assign opcode     = instr_i[6:0];
  assign funct3     = instr_i[14:12];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  assign jump_offset_o = imm_j;
  assign lsu_wdata_o   = rs2_data_i;

  always_comb begin
    alu_op_o = alu_add;
    alu_a_o  = rs1_data_i;
    alu_b_o  = imm_i;
    wb_alu   = 1'b0;
    wb_imm   = 1'b0;
    is_jal   = 1'b0;
    is_mem   = 1'b0;
    lsu_we_o = 1'b0;
    case (opcode)
      opc_op: begin
        alu_b_o = rs2_data_i;
        wb_alu  = 1'b1;
        case (funct3)
          3'b000:  alu_op_o = instr_i[30] ? alu_sub : alu_add;
          3'b010:  alu_op_o = alu_slt;
          3'b100:  alu_op_o = alu_xor;
          3'b110:  alu_op_o = alu_or;
          3'b111:  alu_op_o = alu_and;
          default: wb_alu = 1'b0;
        endcase
      end
      // Only ADDI among the immediate forms
      opc_op_imm: wb_alu = (funct3 == 3'b000);
      opc_lui:    wb_imm = 1'b1;
      // Link value pc + 4 comes out of the ALU
      opc_jal: begin
        alu_a_o = pc_i;
        alu_b_o = 32'd4;
        wb_alu  = 1'b1;
        is_jal  = 1'b1;
      end
      opc_load:   is_mem = (funct3 == 3'b010);
      opc_store: begin
        alu_b_o  = imm_s;
        is_mem   = (funct3 == 3'b010);
        lsu_we_o = 1'b1;
      end
      // Anything else retires as no operation
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  assign id_ready_o = (state_q == decode);
  assign fire       = instr_valid_i & id_ready_o;
  assign lsu_req_o  = fire & is_mem;
  assign pc_set_o   = fire & is_jal;

  always_comb begin
    state_d = state_q;
    case (state_q)
      decode:   if (lsu_req_o) state_d = wait_lsu;
      wait_lsu: if (lsu_done_i) state_d = decode;
      default:  state_d = decode;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= decode;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu_req_o) begin
      load_q    <= ~lsu_we_o;
      load_rd_q <= instr_i[11:7];
    end
  end

  // Load data is written back in the cycle the LSU finishes
  always_comb begin
    if (state_q == wait_lsu) begin
      rd_we_o    = lsu_done_i & load_q;
      rd_addr_o  = load_rd_q;
      rd_wdata_o = lsu_rdata_i;
    end else begin
      rd_we_o    = fire & (wb_alu | wb_imm);
      rd_addr_o  = instr_i[11:7];
      rd_wdata_o = wb_imm ? imm_u : alu_result_i;
    end
  end

  // LSU only reports an access that ID is waiting for
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_done_i |-> state_q == wait_lsu);

endmodule

/* rtl/if_stage.sv */
// Instruction fetch stage
//   fetch PC and one outstanding instruction request
//   one-entry fetch buffer, bypassed on the response cycle
//   flush and response discard on a jump

`timescale 1ns/1ps

module if_stage (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,

  // Instruction port
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,

  // To ID stage
  output logic            instr_valid_o,
  output core_pkg::word_t instr_o,
  output core_pkg::word_t pc_o,
  input  logic            id_ready_i,
  input  logic            pc_set_i,
  input  core_pkg::word_t jump_target_i
);

  import core_pkg::*;

  logic  fetch_en_q;
  word_t pc_q;
  logic  pend_q;
  word_t pend_pc_q;
  logic  discard_q;
  logic  buf_valid_q;
  word_t buf_instr_q;
  word_t buf_pc_q;

  logic  rsp_valid;
  logic  accept;
  logic  req_granted;

  // Boot address is used directly until the first fetch is under way
  assign instr_addr_o = fetch_en_q ? pc_q : boot_addr_i;

  // No new request while one is outstanding or the buffer stays full.
  // A jump in ID blocks the sequential fetch of this cycle
  assign instr_req_o = (fetch_enable_i | fetch_en_q) & ~pend_q &
                       (~buf_valid_q | id_ready_i) & ~pc_set_i;
  assign req_granted = instr_req_o & instr_gnt_i;

  assign rsp_valid = instr_rvalid_i & ~discard_q;

  // Buffered instruction first, else the response of this cycle
  assign instr_valid_o = buf_valid_q | rsp_valid;
  assign instr_o       = buf_valid_q ? buf_instr_q : instr_rdata_i;
  assign pc_o          = buf_valid_q ? buf_pc_q : pend_pc_q;
  assign accept        = instr_valid_o & id_ready_i;

  ////////////////////////////////////////
  // Fetch control
  ////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q  <= 1'b0;
      pc_q        <= '0;
      pend_q      <= 1'b0;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (fetch_enable_i) begin
        fetch_en_q <= 1'b1;
      end

      if (req_granted) begin
        pc_q <= instr_addr_o + 32'd4;
      end else if (pc_set_i) begin
        pc_q <= jump_target_i;
      end else if (!fetch_en_q) begin
        pc_q <= boot_addr_i;
      end

      if (req_granted) begin
        pend_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        pend_q <= 1'b0;
      end

      // Response of a request granted before the jump is dropped
      if (instr_rvalid_i) begin
        discard_q <= 1'b0;
      end else if (pc_set_i && pend_q) begin
        discard_q <= 1'b1;
      end

      if (pc_set_i || accept) begin
        buf_valid_q <= 1'b0;
      end else if (rsp_valid) begin
        buf_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_granted) begin
      pend_pc_q <= instr_addr_o;
    end
    if (rsp_valid && !buf_valid_q) begin
      buf_instr_q <= instr_rdata_i;
      buf_pc_q    <= pend_pc_q;
    end
  end

  // Address held until the memory grants the request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // Memory only answers a granted request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> pend_q);

endmodule

/* rtl/load_store_unit.sv */
// Load/store unit
//   registers one word access and holds it until grant
//   waits for rvalid and returns load data

`timescale 1ns/1ps

module load_store_unit (
  input  logic            clk_i,
  input  logic            rst_ni,

  // From ID stage
  input  logic            lsu_req_i,
  input  logic            lsu_we_i,
  input  core_pkg::word_t lsu_addr_i,
  input  core_pkg::word_t lsu_wdata_i,
  output logic            lsu_done_o,
  output core_pkg::word_t lsu_rdata_o,

  // Data port
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i
);

  import core_pkg::*;

  logic  req_q;
  logic  wait_q;
  logic  we_q;
  word_t addr_q;
  word_t wdata_q;

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  // Stores complete on rvalid as well
  assign lsu_done_o  = wait_q & data_rvalid_i;
  assign lsu_rdata_o = data_rdata_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (lsu_req_i) begin
        req_q <= 1'b1;
      end else if (data_gnt_i) begin
        req_q <= 1'b0;
      end

      if (req_q && data_gnt_i) begin
        wait_q <= 1'b1;
      end else if (data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Access held stable on the port until grant
  always_ff @(posedge clk_i) begin
    if (lsu_req_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  // ID never issues while an access is still in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> !req_q && !wait_q);

endmodule

/* rtl/register_file.sv */
// Register file
//   two read ports, one write port
//   x0 reads as zero, 16 or 32 entries

`timescale 1ns/1ps

module register_file #(
  parameter bit rv32e = 1'b0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i
);

  import core_pkg::*;

  localparam int unsigned num_regs  = rv32e ? 16 : 32;
  // Index bit 4 ignored with 16 registers
  localparam reg_addr_t   addr_mask = rv32e ? 5'h0f : 5'h1f;

  word_t     regs_q [num_regs];
  reg_addr_t waddr;

  assign waddr      = waddr_i & addr_mask;
  assign rs1_data_o = regs_q[rs1_addr_i & addr_mask];
  assign rs2_data_o = regs_q[rs2_addr_i & addr_mask];

  assign regs_q[0] = '0;

  for (genvar i = 1; i < num_regs; i++) begin : g_regs
    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[i] <= '0;
      end else if (we_i && waddr == reg_addr_t'(i)) begin
        regs_q[i] <= wdata_i;
      end
    end
  end

endmodule

/* rtl/ex_block.sv */
// Execute block
//   ALU with add, sub, logic ops and signed compare
//   jump target adder

`timescale 1ns/1ps

module ex_block (
  input  core_pkg::alu_op_e alu_op_i,
  input  core_pkg::word_t   alu_a_i,
  input  core_pkg::word_t   alu_b_i,
  output core_pkg::word_t   alu_result_o,
  input  core_pkg::word_t   pc_i,
  input  core_pkg::word_t   jump_offset_i,
  output core_pkg::word_t   jump_target_o
);

  import core_pkg::*;

  logic less_than;

  assign less_than = $signed(alu_a_i) < $signed(alu_b_i);

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      alu_add: alu_result_o = alu_a_i + alu_b_i;
      alu_sub: alu_result_o = alu_a_i - alu_b_i;
      alu_and: alu_result_o = alu_a_i & alu_b_i;
      alu_or:  alu_result_o = alu_a_i | alu_b_i;
      alu_xor: alu_result_o = alu_a_i ^ alu_b_i;
      alu_slt: alu_result_o = {31'b0, less_than};
      default: alu_result_o = alu_a_i + alu_b_i;
    endcase
  end

  // Own adder so a jump needs no ALU cycle for its target
  assign jump_target_o = pc_i + jump_offset_i;

endmodule

/* rtl/core_pkg.sv */
// Shared definitions of the core
//   data word and register index types
//   ALU operation and controller state encodings
//   opcodes of the supported RV32I subset

package core_pkg;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Data words, addresses and instructions
  typedef logic [31:0] word_t;

  // Register index with bit 4 unused for 16 registers
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  // Decode runs freely while wait_lsu holds ID during a memory access
  typedef enum logic {
    decode,
    wait_lsu
  } ctrl_state_e;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  localparam logic [6:0] opc_op     = 7'b011_0011;
  localparam logic [6:0] opc_op_imm = 7'b001_0011;
  localparam logic [6:0] opc_lui    = 7'b011_0111;
  localparam logic [6:0] opc_jal    = 7'b110_1111;
  localparam logic [6:0] opc_load   = 7'b000_0011;
  localparam logic [6:0] opc_store  = 7'b010_0011;

endpackage
